// ==== tests/conv_tests.txt ====
# K w00 w01 w02 w10 w11 w12 w20 w21 w22 (row by row) | F lrelu | P row0 row1 row2 row3
# E sum0 sum1 last; a frame ends at the next K or F line or at the end of the file
# Plain frame of five columns
K 1 0 -1 2 1 0 0 1 1
F 0
P 1 2 3 4
P 5 6 7 8
P 2 0 1 3
P 4 4 2 1
P 0 3 5 2
E 17 26 0
E 16 21 0
E 13 4 1
# Kernel reload, negative sums through the leaky ReLU
K -1 -2 -3 0 -1 0 -2 0 -1
F 1
P 10 20 30 40
P 5 5 5 5
P 0 10 20 30
P 8 6 4 2
E -14 -22 0
E -7 -10 1
# Same pixels right after, activation off
F 0
P 10 20 30 40
P 5 5 5 5
P 0 10 20 30
P 8 6 4 2
E -105 -175 0
E -53 -75 1
# First kernel again, mixed signs
K 1 0 -1 2 1 0 0 1 1
F 1
P 0 0 0 0
P 0 0 0 0
P 200 1 1 1
P 1 2 3 4
P 0 0 0 0
P 3 1 4 1
E -25 0 0
E 4 4 0
E 207 10 0
E 6 8 1
# Shortest frame, back to back with the previous one
F 0
P 9 8 7 6
P 1 1 1 1
P 50 0 0 0
E -23 24 1

// ==== list.f ====
rtl/conv_pkg.sv
rtl/axis_slice.sv
rtl/kernel_store.sv
rtl/conv_engine.sv
rtl/leaky_relu.sv
rtl/conv_accel_top.sv
tests/conv_accel_checker.sv
tests/conv_accel_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module conv_accel_tb -f list.f -o conv_accel_sim
output=$(./obj_dir/conv_accel_sim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'test passed'; then
  exit 0
fi
exit 1

// ==== tests/conv_accel_tb.sv ====
module conv_accel_tb;
  import conv_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int CYCLES_PER_LINE = 40;

  logic         aclk;
  logic         rst;
  pixel_beat_t  s_pixels;
  logic         s_pixels_valid;
  logic         s_pixels_ready;
  weight_beat_t s_weights;
  logic         s_weights_valid;
  logic         s_weights_ready;
  conv_beat_t   m_out;
  logic         m_out_valid;
  logic         m_out_ready;

  // Input beats in file order, 1 marks a pixel beat and 0 a weight beat
  bit           kind_q[$];
  pixel_beat_t  pixel_q[$];
  weight_beat_t weight_q[$];
  conv_beat_t   expect_q[$];

  int line_count;
  int open_pixel;
  bit running;

  conv_accel_top #(
    .LRELU_SHIFT (3)
  ) conv_accel_top_inst (
    .aclk            (aclk),
    .rst             (rst),
    .s_pixels        (s_pixels),
    .s_pixels_valid  (s_pixels_valid),
    .s_pixels_ready  (s_pixels_ready),
    .s_weights       (s_weights),
    .s_weights_valid (s_weights_valid),
    .s_weights_ready (s_weights_ready),
    .m_out           (m_out),
    .m_out_valid     (m_out_valid),
    .m_out_ready     (m_out_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  task automatic step_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopping at the first mismatch");
  endtask

  // Closes the open frame by flagging its final column
  function automatic void mark_frame_end();
    pixel_beat_t beat;
    if (open_pixel >= 0) begin
      beat = pixel_q[open_pixel];
      beat.last = 1'b1;
      pixel_q[open_pixel] = beat;
    end
    open_pixel = -1;
  endfunction

  task automatic load_tests();
    int           fd;
    int           n;
    bit           bad;
    string        line;
    int           w [9];
    int           p [4];
    int           s0;
    int           s1;
    int           last_flag;
    int           flag;
    weight_beat_t wb;
    pixel_beat_t  pb;
    conv_beat_t   eb;

    flag = 0;
    open_pixel = -1;
    fd = $fopen("tests/conv_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/conv_tests.txt");
      $display("test failed");
      $fatal(1, "missing test data");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      line_count++;
      bad = 1'b0;
      case (line.getc(0))
        "K": begin
          mark_frame_end();
          n = $sscanf(line, "K %d %d %d %d %d %d %d %d %d",
                      w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], w[8]);
          bad = (n != 9);
          // One beat per kernel column
          for (int c = 0; c < KERNEL; c++) begin
            for (int i = 0; i < KERNEL; i++) begin
              wb.column[i] = weight_t'(w[i * KERNEL + c]);
            end
            wb.last = (c == KERNEL - 1);
            weight_q.push_back(wb);
            kind_q.push_back(1'b0);
          end
        end
        "F": begin
          mark_frame_end();
          n = $sscanf(line, "F %d", flag);
          bad = (n != 1);
        end
        "P": begin
          n = $sscanf(line, "P %d %d %d %d", p[0], p[1], p[2], p[3]);
          bad = (n != 4);
          for (int r = 0; r < UNITS_EDGES; r++) begin
            pb.words[r] = 8'(p[r]);
          end
          pb.is_lrelu = flag[0];
          pb.last     = 1'b0;
          pixel_q.push_back(pb);
          kind_q.push_back(1'b1);
          open_pixel = pixel_q.size() - 1;
        end
        "E": begin
          n = $sscanf(line, "E %d %d %d", s0, s1, last_flag);
          bad = (n != 3);
          eb.sums[0]  = sum_t'(s0);
          eb.sums[1]  = sum_t'(s1);
          eb.is_lrelu = flag[0];
          eb.last     = last_flag[0];
          expect_q.push_back(eb);
        end
        default: ;
      endcase
      if (bad) begin
        $display("Malformed line in tests/conv_tests.txt: %s", line);
        $display("test failed");
        $fatal(1, "bad test data");
      end
    end
    mark_frame_end();
    $fclose(fd);
  endtask

  task automatic send_weight(input weight_beat_t beat);
    logic taken;
    s_weights       = beat;
    s_weights_valid = 1'b1;
    do begin
      // Ready comes from a register and holds until the next edge
      taken = s_weights_ready;
      step_cycle();
    end while (!taken);
    s_weights_valid = 1'b0;
  endtask

  task automatic send_pixel(input pixel_beat_t beat);
    logic taken;
    s_pixels       = beat;
    s_pixels_valid = 1'b1;
    do begin
      taken = s_pixels_ready;
      step_cycle();
    end while (!taken);
    s_pixels_valid = 1'b0;
  endtask

  task automatic compare_beat(input conv_beat_t got, input conv_beat_t want, input int index);
    for (int u = 0; u < UNITS; u++) begin
      assert (got.sums[u] == want.sums[u])
        else report_mismatch($sformatf("output %0d sums[%0d] is %0d, expected %0d",
                                       index, u, got.sums[u], want.sums[u]));
    end
    assert (got.is_lrelu == want.is_lrelu)
      else report_mismatch($sformatf("output %0d is_lrelu is %0b, expected %0b",
                                     index, got.is_lrelu, want.is_lrelu));
    assert (got.last == want.last)
      else report_mismatch($sformatf("output %0d last is %0b, expected %0b",
                                     index, got.last, want.last));
  endtask

  initial begin
    rst = 1'b1;
    void'($urandom(83));
    load_tests();
    repeat (3) @(posedge aclk);
    #1;
    rst = 1'b0;
    running = 1'b1;
  end

  initial begin : driver
    int pi;
    int wi;
    s_pixels        = '0;
    s_pixels_valid  = 1'b0;
    s_weights       = '0;
    s_weights_valid = 1'b0;
    pi = 0;
    wi = 0;
    wait (running);
    foreach (kind_q[k]) begin
      repeat ($urandom % 3) step_cycle();
      if (kind_q[k]) begin
        send_pixel(pixel_q[pi]);
        pi++;
      end else begin
        send_weight(weight_q[wi]);
        wi++;
      end
    end
  end

  initial begin : monitor
    int matched;
    matched = 0;
    m_out_ready = 1'b0;
    wait (running);
    while (matched < expect_q.size()) begin
      m_out_ready = ($urandom % 4) != 0;
      if (m_out_valid && m_out_ready) begin
        compare_beat(m_out, expect_q[matched], matched);
        matched++;
      end
      step_cycle();
    end
    // Nothing may follow the last expected beat
    m_out_ready = 1'b1;
    repeat (20) begin
      assert (!m_out_valid)
        else report_mismatch("m_out_valid after the last expected output");
      step_cycle();
    end
    $display("test passed");
    $finish;
  end

  initial begin : watchdog
    wait (running);
    repeat (line_count * CYCLES_PER_LINE) @(posedge aclk);
    $display("Timeout: outputs still missing after %0d clock cycles",
             line_count * CYCLES_PER_LINE);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== tests/conv_accel_checker.sv ====
module conv_accel_checker (
  input logic                 aclk,
  input logic                 rst,
  input conv_pkg::conv_beat_t m_out,
  input logic                 m_out_valid,
  input logic                 m_out_ready,
  input logic                 pixels_q_ready,
  input logic                 weights_q_valid,
  input logic                 weights_q_ready,
  input logic                 weights_q_last
);

  // Set once a weight beat closing a kernel has reached the kernel store
  logic kernel_seen;

  always_ff @(posedge aclk) begin
    if (rst) begin
      kernel_seen <= 1'b0;
    end else if (weights_q_valid && weights_q_ready && weights_q_last) begin
      kernel_seen <= 1'b1;
    end
  end

  // Output register comes out of reset empty
  out_idle_after_reset: assert property (@(posedge aclk) rst |=> !m_out_valid)
    else $error("m_out_valid high in the cycle after reset");

  out_held_until_ready: assert property (@(posedge aclk) disable iff (rst)
    m_out_valid && !m_out_ready |=> m_out_valid && $stable(m_out))
    else $error("m_out changed or dropped before m_out_ready");

  // No pixel column reaches the engine before a kernel is loaded
  pixels_wait_for_kernel: assert property (@(posedge aclk) disable iff (rst)
    !kernel_seen |-> !pixels_q_ready)
    else $error("engine ready for pixels before any kernel was accepted");

endmodule

bind conv_accel_top conv_accel_checker conv_accel_checker_inst (
  .aclk            (aclk),
  .rst             (rst),
  .m_out           (m_out),
  .m_out_valid     (m_out_valid),
  .m_out_ready     (m_out_ready),
  .pixels_q_ready  (pixels_q_ready),
  .weights_q_valid (weights_q_valid),
  .weights_q_ready (weights_q_ready),
  .weights_q_last  (weights_q.last)
);

// ==== rtl/conv_accel_top.sv ====
module conv_accel_top #(
  parameter int LRELU_SHIFT = 3
) (
  input  logic                   aclk,
  input  logic                   rst,

  input  conv_pkg::pixel_beat_t  s_pixels,
  input  logic                   s_pixels_valid,
  output logic                   s_pixels_ready,

  input  conv_pkg::weight_beat_t s_weights,
  input  logic                   s_weights_valid,
  output logic                   s_weights_ready,

  output conv_pkg::conv_beat_t   m_out,
  output logic                   m_out_valid,
  input  logic                   m_out_ready
);
  import conv_pkg::*;

  weight_beat_t weights_q;
  logic         weights_q_valid;
  logic         weights_q_ready;

  pixel_beat_t  pixels_q;
  logic         pixels_q_valid;
  logic         pixels_q_ready;

  kernel_t      kernel;
  logic         kernel_valid;
  logic         frame_active;

  conv_beat_t   conv;
  logic         conv_valid;
  logic         conv_ready;

  axis_slice #(
    .payload_t (weight_beat_t)
  ) weight_slice_inst (
    .aclk    (aclk),
    .rst     (rst),
    .s_data  (s_weights),
    .s_valid (s_weights_valid),
    .s_ready (s_weights_ready),
    .m_data  (weights_q),
    .m_valid (weights_q_valid),
    .m_ready (weights_q_ready)
  );

  kernel_store kernel_store_inst (
    .aclk         (aclk),
    .rst          (rst),
    .s_weights    (weights_q),
    .s_valid      (weights_q_valid),
    .s_ready      (weights_q_ready),
    .frame_active (frame_active),
    .kernel       (kernel),
    .kernel_valid (kernel_valid)
  );

  axis_slice #(
    .payload_t (pixel_beat_t)
  ) pixel_slice_inst (
    .aclk    (aclk),
    .rst     (rst),
    .s_data  (s_pixels),
    .s_valid (s_pixels_valid),
    .s_ready (s_pixels_ready),
    .m_data  (pixels_q),
    .m_valid (pixels_q_valid),
    .m_ready (pixels_q_ready)
  );

  conv_engine conv_engine_inst (
    .aclk         (aclk),
    .rst          (rst),
    .s_pixels     (pixels_q),
    .s_valid      (pixels_q_valid),
    .s_ready      (pixels_q_ready),
    .kernel       (kernel),
    .kernel_valid (kernel_valid),
    .frame_active (frame_active),
    .m_conv       (conv),
    .m_valid      (conv_valid),
    .m_ready      (conv_ready)
  );

  leaky_relu #(
    .LRELU_SHIFT (LRELU_SHIFT)
  ) leaky_relu_inst (
    .aclk    (aclk),
    .rst     (rst),
    .s_conv  (conv),
    .s_valid (conv_valid),
    .s_ready (conv_ready),
    .m_out   (m_out),
    .m_valid (m_out_valid),
    .m_ready (m_out_ready)
  );

endmodule

// ==== rtl/leaky_relu.sv ====
module leaky_relu #(
  parameter int LRELU_SHIFT = 3
) (
  input  logic                 aclk,
  input  logic                 rst,
  input  conv_pkg::conv_beat_t s_conv,
  input  logic                 s_valid,
  output logic                 s_ready,
  output conv_pkg::conv_beat_t m_out,
  output logic                 m_valid,
  input  logic                 m_ready
);
  import conv_pkg::*;

  conv_beat_t act;

  assign s_ready = !m_valid || m_ready;

  always_comb begin
    act = s_conv;
    for (int u = 0; u < UNITS; u++) begin
      // Negative slope of 2^-LRELU_SHIFT
      if (s_conv.is_lrelu && ($signed(s_conv.sums[u]) < 0)) begin
        act.sums[u] = $signed(s_conv.sums[u]) >>> LRELU_SHIFT;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid && s_ready) begin
      m_out <= act;
    end
  end

endmodule

// ==== rtl/conv_engine.sv ====
module conv_engine (
  input  logic                  aclk,
  input  logic                  rst,
  input  conv_pkg::pixel_beat_t s_pixels,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  conv_pkg::kernel_t     kernel,
  input  logic                  kernel_valid,
  output logic                  frame_active,
  output conv_pkg::conv_beat_t  m_conv,
  output logic                  m_valid,
  input  logic                  m_ready
);
  import conv_pkg::*;

  localparam col_t FIRST_OUT_COL = col_t'(KERNEL - 1);

  // Dot product of unit u's pixels with kernel column j
  sum_t col_dot [UNITS][KERNEL];

  sum_t s1_dot [UNITS][KERNEL];
  logic s1_valid;
  logic s1_has_out;
  logic s1_lrelu;
  logic s1_last;

  // part_a holds cols c-2 and c-1 for the next output, part_b col c-1 only
  sum_t part_a [UNITS];
  sum_t part_b [UNITS];

  col_t col_cnt;
  logic in_frame;
  logic advance;
  logic take;

  // Whole pipeline holds while the output waits
  assign advance = !(m_valid && !m_ready);
  assign s_ready = kernel_valid && advance;
  assign take    = s_valid && s_ready;

  // Also covers the cycle in which the first column is taken
  assign frame_active = in_frame || (s_valid && kernel_valid);

  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      for (int j = 0; j < KERNEL; j++) begin
        col_dot[u][j] = '0;
        for (int i = 0; i < KERNEL; i++) begin
          col_dot[u][j] += sum_t'($signed(kernel[i][j]))
                         * sum_t'($signed({1'b0, s_pixels.words[u + i]}));
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (rst) begin
      col_cnt  <= '0;
      in_frame <= 1'b0;
    end else if (take) begin
      col_cnt  <= s_pixels.last ? '0 : col_cnt + 1'b1;
      in_frame <= !s_pixels.last;
    end
  end

  // Stage one
  always_ff @(posedge aclk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= take;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      s1_dot     <= col_dot;
      s1_has_out <= (col_cnt >= FIRST_OUT_COL);
      s1_lrelu   <= s_pixels.is_lrelu;
      s1_last    <= s_pixels.last;
    end
  end

  // Stage two
  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
    end else if (advance) begin
      m_valid <= s1_valid && s1_has_out;
    end
  end

  always_ff @(posedge aclk) begin
    if (advance && s1_valid) begin
      for (int u = 0; u < UNITS; u++) begin
        m_conv.sums[u] <= part_a[u] + s1_dot[u][2];
        part_a[u]      <= part_b[u] + s1_dot[u][1];
        part_b[u]      <= s1_dot[u][0];
      end
      m_conv.is_lrelu <= s1_lrelu;
      m_conv.last     <= s1_last;
    end
  end

endmodule

// ==== rtl/kernel_store.sv ====
module kernel_store (
  input  logic                   aclk,
  input  logic                   rst,
  input  conv_pkg::weight_beat_t s_weights,
  input  logic                   s_valid,
  output logic                   s_ready,
  input  logic                   frame_active,
  output conv_pkg::kernel_t      kernel,
  output logic                   kernel_valid
);
  import conv_pkg::*;

  localparam int CNT_BITS = $clog2(KERNEL);
  localparam logic [CNT_BITS-1:0] LAST_COL = CNT_BITS'(KERNEL - 1);

  logic [CNT_BITS-1:0] beat_cnt;
  logic                take;
  logic                at_last_col;

  // No kernel changes while a frame runs through the engine
  assign s_ready     = !frame_active;
  assign take        = s_valid && s_ready;
  assign at_last_col = (beat_cnt == LAST_COL);

  always_ff @(posedge aclk) begin
    if (rst) begin
      beat_cnt     <= '0;
      kernel_valid <= 1'b0;
    end else if (take) begin
      if (at_last_col || s_weights.last) begin
        beat_cnt     <= '0;
        // Only a complete kernel closed by last is usable
        kernel_valid <= at_last_col && s_weights.last;
      end else begin
        beat_cnt     <= beat_cnt + 1'b1;
        kernel_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      for (int i = 0; i < KERNEL; i++) begin
        kernel[i][beat_cnt] <= s_weights.column[i];
      end
    end
  end

endmodule

// ==== rtl/axis_slice.sv ====
module axis_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     aclk,
  input  logic     rst,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     take;
  logic     load_out;

  // Ready comes from a register, never from m_ready
  assign s_ready  = !skid_valid;
  assign take     = s_valid && s_ready;
  assign load_out = m_ready || !m_valid;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      m_valid    <= skid_valid || take;
      skid_valid <= 1'b0;
    end else if (take) begin
      // Output is stalled, park the beat
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load_out) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (take) begin
      skid_data <= s_data;
    end
  end

endmodule

// ==== rtl/conv_pkg.sv ====
package conv_pkg;

  localparam int WORD_WIDTH  = 8;
  localparam int ACC_WIDTH   = 32;
  localparam int KERNEL      = 3;
  localparam int UNITS       = 2;
  // Two extra rows give the 3-high kernel its edges
  localparam int UNITS_EDGES = UNITS + KERNEL - 1;

  localparam int COLS_MAX    = 384;
  localparam int COL_BITS    = $clog2(COLS_MAX);

  typedef logic [COL_BITS-1:0] col_t;

  typedef logic signed [WORD_WIDTH-1:0] weight_t;
  typedef logic signed [ACC_WIDTH-1:0]  sum_t;

  // Image column, row 0 in words[0]
  typedef struct packed {
    logic [UNITS_EDGES-1:0][WORD_WIDTH-1:0] words;
    logic                                   is_lrelu;
    logic                                   last;
  } pixel_beat_t;

  // One kernel column, kernel row i in column[i]
  typedef struct packed {
    weight_t [KERNEL-1:0] column;
    logic                 last;
  } weight_beat_t;

  // Indexed as [row][col]
  typedef weight_t [KERNEL-1:0][KERNEL-1:0] kernel_t;

  typedef struct packed {
    sum_t [UNITS-1:0] sums;
    logic             is_lrelu;
    logic             last;
  } conv_beat_t;

endpackage
